// File: cache_sim_config.svh
`ifndef CACHE_SIM_CONFIG_SVH
`define CACHE_SIM_CONFIG_SVH

////////////////////////////////////////////////////////////
// Address and block geometry
////////////////////////////////////////////////////////////

// Byte address width seen by both cache levels
`define CACHE_ADDR_W 32
// Block size in bytes, so the low 4 address bits are the offset
`define CACHE_BLOCK_BYTES 16

////////////////////////////////////////////////////////////
// Per-level organisation
////////////////////////////////////////////////////////////

`define CACHE_L1_SETS 4
`define CACHE_L1_WAYS 2
`define CACHE_L2_SETS 8
`define CACHE_L2_WAYS 4

// Set index widths follow from the set counts
`define CACHE_L1_IDX_W $clog2(`CACHE_L1_SETS)
`define CACHE_L2_IDX_W $clog2(`CACHE_L2_SETS)

// Width of every statistic counter
`define CACHE_COUNT_W 16

`endif

// File: cache_sim_pkg.sv
package cache_sim_pkg;

  `include "cache_sim_config.svh"

  // Operation carried by an access
  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } access_op_e;

  // Access sequencer states
  typedef enum logic [1:0] {
    st_idle   = 2'd0,
    st_lookup = 2'd1,
    st_update = 2'd2
  } ctrl_state_e;

  // Request as presented at the top level
  typedef struct packed {
    logic [`CACHE_ADDR_W-1:0] addr;
    access_op_e               op;
  } access_req_t;

  // Address split for both levels, tags kept at full width
  typedef struct packed {
    logic [`CACHE_ADDR_W-1:0]   l1_tag;
    logic [`CACHE_L1_IDX_W-1:0] l1_index;
    logic [`CACHE_ADDR_W-1:0]   l2_tag;
    logic [`CACHE_L2_IDX_W-1:0] l2_index;
    access_op_e                 op;
  } decoded_addr_t;

  // Outcome of one finished access
  typedef struct packed {
    logic       l1_hit;
    // Set when L2 took part in the access, i.e. on an L1 miss
    logic       l2_lookup;
    logic       l2_hit;
    access_op_e op;
  } access_result_t;

  typedef struct packed {
    logic [`CACHE_COUNT_W-1:0] accesses;
    logic [`CACHE_COUNT_W-1:0] writes;
    logic [`CACHE_COUNT_W-1:0] l1_hits;
    logic [`CACHE_COUNT_W-1:0] l1_misses;
    logic [`CACHE_COUNT_W-1:0] l2_hits;
    logic [`CACHE_COUNT_W-1:0] l2_misses;
  } cache_stats_t;

endpackage

// File: cache_addr_decode.sv
`timescale 1ns/1ps
`include "cache_sim_config.svh"

module cache_addr_decode (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         accept,
  input  cache_sim_pkg::access_req_t   req,
  output cache_sim_pkg::decoded_addr_t dec
);

  // Bytes covered by one full pass over the sets of each level
  localparam int L1_SPAN = `CACHE_BLOCK_BYTES * `CACHE_L1_SETS;
  localparam int L2_SPAN = `CACHE_BLOCK_BYTES * `CACHE_L2_SETS;

  // Block number of the request, offset bits removed
  logic [`CACHE_ADDR_W-1:0] block_num;

  assign block_num = req.addr / `CACHE_BLOCK_BYTES;

  // The split address is held from the accepting edge until the next accept
  // so the lookup and update stages both see the same set
  always_ff @(posedge clk) begin
    if (reset) begin
      dec <= '0;
    end else if (accept) begin
      // Tag is whatever is left above offset and index
      dec.l1_tag   <= `CACHE_ADDR_W'(req.addr / L1_SPAN);
      dec.l1_index <= `CACHE_L1_IDX_W'(block_num % `CACHE_L1_SETS);
      dec.l2_tag   <= `CACHE_ADDR_W'(req.addr / L2_SPAN);
      dec.l2_index <= `CACHE_L2_IDX_W'(block_num % `CACHE_L2_SETS);
      dec.op       <= req.op;
    end
  end

endmodule

// File: cache_tag_set.sv
`timescale 1ns/1ps
`include "cache_sim_config.svh"

module cache_tag_set #(
  parameter int   SETS  = 4,
  parameter int   WAYS  = 2,
  localparam int  IDX_W = (SETS > 1) ? $clog2(SETS) : 1
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     lru_mode,
  input  logic [IDX_W-1:0]         index,
  input  logic [`CACHE_ADDR_W-1:0] tag,
  input  logic                     lookup,
  input  logic                     update,
  output logic                     hit
);

  localparam int WAY_W = (WAYS > 1) ? $clog2(WAYS) : 1;

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////

  // Position 0 of every set is the newest entry
  logic [`CACHE_ADDR_W-1:0] tag_mem   [SETS][WAYS];
  logic [WAYS-1:0]          valid_mem [SETS];

  // Combinational search of the addressed set
  logic             match;
  logic [WAY_W-1:0] match_pos;

  // Position registered with the hit flag, used by the update
  logic [WAY_W-1:0] hit_pos;

  // Shift control for the update edge
  logic             shift_en;
  logic [WAY_W-1:0] shift_top;

  ////////////////////////////////////////////////////////////
  // Lookup
  ////////////////////////////////////////////////////////////

  // Walking down from the oldest entry leaves the newest match in match_pos
  always_comb begin
    match     = 1'b0;
    match_pos = '0;
    for (int w = WAYS - 1; w >= 0; w--) begin
      if (valid_mem[index][w] && (tag_mem[index][w] == tag)) begin
        match     = 1'b1;
        match_pos = WAY_W'(w);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      hit <= 1'b0;
    end else if (lookup) begin
      hit <= match;
    end
  end

  always_ff @(posedge clk) begin
    if (lookup) begin
      hit_pos <= match_pos;
    end
  end

  ////////////////////////////////////////////////////////////
  // Update
  ////////////////////////////////////////////////////////////

  // A miss shifts the whole set and drops the last entry
  // An LRU hit shifts only the entries in front of the hit one
  // A FIFO hit leaves the order alone
  always_comb begin
    shift_en  = update && (!hit || lru_mode);
    shift_top = hit ? hit_pos : WAY_W'(WAYS - 1);
  end

  // On an LRU hit the tag written to position 0 equals the hit entry,
  // which amounts to moving it to the front
  always_ff @(posedge clk) begin
    if (shift_en) begin
      for (int w = 1; w < WAYS; w++) begin
        if (w <= shift_top) begin
          tag_mem[index][w] <= tag_mem[index][w-1];
        end
      end
      tag_mem[index][0] <= tag;
    end
  end

  // Valid bits follow their tags and are all cleared by reset
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int s = 0; s < SETS; s++) begin
        valid_mem[s] <= '0;
      end
    end else if (shift_en) begin
      for (int w = 1; w < WAYS; w++) begin
        if (w <= shift_top) begin
          valid_mem[index][w] <= valid_mem[index][w-1];
        end
      end
      valid_mem[index][0] <= 1'b1;
    end
  end

endmodule

// File: cache_sim_control.sv
`timescale 1ns/1ps

module cache_sim_control (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          access_valid,
  input  cache_sim_pkg::access_op_e     op,
  input  logic                          l1_hit,
  input  logic                          l2_hit,
  output logic                          ready,
  output logic                          accept,
  output logic                          l1_lookup,
  output logic                          l2_lookup,
  output logic                          l1_update,
  output logic                          l2_update,
  output logic                          done,
  output cache_sim_pkg::access_result_t result
);

  cache_sim_pkg::ctrl_state_e state;
  cache_sim_pkg::ctrl_state_e state_next;

  ////////////////////////////////////////////////////////////
  // Sequencing
  ////////////////////////////////////////////////////////////

  // One access at a time, since an update can change the set the next one reads
  assign ready  = (state == cache_sim_pkg::st_idle);
  assign accept = access_valid && ready;

  always_comb begin
    state_next = state;
    case (state)
      cache_sim_pkg::st_idle:   if (accept) state_next = cache_sim_pkg::st_lookup;
      cache_sim_pkg::st_lookup: state_next = cache_sim_pkg::st_update;
      cache_sim_pkg::st_update: state_next = cache_sim_pkg::st_idle;
      default:                  state_next = cache_sim_pkg::st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= cache_sim_pkg::st_idle;
    end else begin
      state <= state_next;
    end
  end

  // Both levels search in the cycle after the accepting edge
  assign l1_lookup = (state == cache_sim_pkg::st_lookup);
  assign l2_lookup = (state == cache_sim_pkg::st_lookup);

  // L1 is always written: reordered on a hit, filled on a miss
  // L2 only takes part when L1 missed
  assign l1_update = (state == cache_sim_pkg::st_update);
  assign l2_update = (state == cache_sim_pkg::st_update) && !l1_hit;

  ////////////////////////////////////////////////////////////
  // Completion
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      done <= 1'b0;
    end else begin
      done <= (state == cache_sim_pkg::st_update);
    end
  end

  // Result is captured on the update edge and only read while done is high
  always_ff @(posedge clk) begin
    if (state == cache_sim_pkg::st_update) begin
      result.l1_hit    <= l1_hit;
      result.l2_lookup <= !l1_hit;
      result.l2_hit    <= !l1_hit && l2_hit;
      result.op        <= op;
    end
  end

endmodule

// File: cache_stat_counters.sv
`timescale 1ns/1ps

module cache_stat_counters (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          done,
  input  cache_sim_pkg::access_result_t result,
  output cache_sim_pkg::cache_stats_t   stats
);

  ////////////////////////////////////////////////////////////
  // Per-access accounting
  ////////////////////////////////////////////////////////////

  // Each finished access bumps the access count and exactly one L1 counter
  always_ff @(posedge clk) begin
    if (reset) begin
      stats <= '0;
    end else if (done) begin
      stats.accesses <= stats.accesses + 1'b1;

      // Writes are counted once regardless of where they hit
      if (result.op == cache_sim_pkg::op_write) begin
        stats.writes <= stats.writes + 1'b1;
      end

      if (result.l1_hit) begin
        stats.l1_hits <= stats.l1_hits + 1'b1;
      end else begin
        stats.l1_misses <= stats.l1_misses + 1'b1;
      end

      // L2 counters only move for accesses that reached L2
      if (result.l2_lookup) begin
        if (result.l2_hit) begin
          stats.l2_hits <= stats.l2_hits + 1'b1;
        end else begin
          stats.l2_misses <= stats.l2_misses + 1'b1;
        end
      end
    end
  end

endmodule

// File: cache_sim_top.sv
`timescale 1ns/1ps
`include "cache_sim_config.svh"

module cache_sim_top (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          access_valid,
  input  cache_sim_pkg::access_req_t    req,
  input  logic                          lru_mode,
  output logic                          ready,
  output logic                          done,
  output cache_sim_pkg::access_result_t result,
  output cache_sim_pkg::cache_stats_t   stats
);

  cache_sim_pkg::decoded_addr_t dec;

  logic accept;
  logic l1_lookup;
  logic l2_lookup;
  logic l1_update;
  logic l2_update;
  logic l1_hit;
  logic l2_hit;

  ////////////////////////////////////////////////////////////
  // Front end and sequencer
  ////////////////////////////////////////////////////////////

  cache_addr_decode u_decode (
    .clk    (clk),
    .reset  (reset),
    .accept (accept),
    .req    (req),
    .dec    (dec)
  );

  // Op comes from the registered request so it matches the address in use
  cache_sim_control u_control (
    .clk          (clk),
    .reset        (reset),
    .access_valid (access_valid),
    .op           (dec.op),
    .l1_hit       (l1_hit),
    .l2_hit       (l2_hit),
    .ready        (ready),
    .accept       (accept),
    .l1_lookup    (l1_lookup),
    .l2_lookup    (l2_lookup),
    .l1_update    (l1_update),
    .l2_update    (l2_update),
    .done         (done),
    .result       (result)
  );

  ////////////////////////////////////////////////////////////
  // Tag stores
  ////////////////////////////////////////////////////////////

  cache_tag_set #(
    .SETS (`CACHE_L1_SETS),
    .WAYS (`CACHE_L1_WAYS)
  ) u_l1 (
    .clk      (clk),
    .reset    (reset),
    .lru_mode (lru_mode),
    .index    (dec.l1_index),
    .tag      (dec.l1_tag),
    .lookup   (l1_lookup),
    .update   (l1_update),
    .hit      (l1_hit)
  );

  cache_tag_set #(
    .SETS (`CACHE_L2_SETS),
    .WAYS (`CACHE_L2_WAYS)
  ) u_l2 (
    .clk      (clk),
    .reset    (reset),
    .lru_mode (lru_mode),
    .index    (dec.l2_index),
    .tag      (dec.l2_tag),
    .lookup   (l2_lookup),
    .update   (l2_update),
    .hit      (l2_hit)
  );

  cache_stat_counters u_stats (
    .clk    (clk),
    .reset  (reset),
    .done   (done),
    .result (result),
    .stats  (stats)
  );

endmodule

// File: cache_sim_properties.sv
`timescale 1ns/1ps

module cache_sim_properties (
  input logic                          clk,
  input logic                          reset,
  input logic                          accept,
  input logic                          ready,
  input logic                          done,
  input cache_sim_pkg::access_result_t result
);

  // Number of assertion failures, read by the testbench at the end of the run
  int fail_count = 0;

  ////////////////////////////////////////////////////////////
  // Access protocol
  ////////////////////////////////////////////////////////////

  // Done is a single-cycle pulse
  done_single_cycle: assert property (@(posedge clk) disable iff (reset)
    done |=> !done)
    else begin
      fail_count++;
      $error("done was high for more than one cycle");
    end

  // Done is set on the second edge after the accepting edge,
  // so it is first sampled high on the third
  done_after_accept: assert property (@(posedge clk) disable iff (reset)
    accept |-> ##3 done)
    else begin
      fail_count++;
      $error("done did not follow an accept two edges later");
    end

  // The sequencer is busy for the lookup and update cycles
  busy_after_accept: assert property (@(posedge clk) disable iff (reset)
    accept |=> !ready ##1 !ready)
    else begin
      fail_count++;
      $error("ready went high before the access finished");
    end

  // L2 can only report a hit when it was consulted
  l2_hit_needs_lookup: assert property (@(posedge clk) disable iff (reset)
    done |-> (!result.l2_hit || result.l2_lookup))
    else begin
      fail_count++;
      $error("result shows an L2 hit without an L2 lookup");
    end

endmodule

bind cache_sim_top cache_sim_properties u_props (
  .clk    (clk),
  .reset  (reset),
  .accept (accept),
  .ready  (ready),
  .done   (done),
  .result (result)
);

// File: cache_sim_tb.sv
`timescale 1ns/1ps
`include "cache_sim_config.svh"

module cache_sim_tb;

  // Cycles allowed for ready or done before a wait gives up
  localparam int WAIT_LIMIT = 8;

  // One access of the stimulus table
  typedef struct packed {
    logic                      rst_before;
    logic                      lru;
    logic [`CACHE_ADDR_W-1:0]  addr;
    cache_sim_pkg::access_op_e op;
    logic                      exp_l1;
    logic                      exp_l2;
    // Extra cycles that access_valid stays high while the DUT is busy
    logic [1:0]                hold;
  } row_t;

  logic                          clk;
  logic                          reset;
  logic                          access_valid;
  cache_sim_pkg::access_req_t    req;
  logic                          lru_mode;
  logic                          ready;
  logic                          done;
  cache_sim_pkg::access_result_t result;
  cache_sim_pkg::cache_stats_t   stats;

  row_t rows[$];

  // Counters the DUT should show, tallied since the last reset
  cache_sim_pkg::cache_stats_t expected_stats;

  int check_count;
  int error_count;

  cache_sim_top u_cache_sim_top (
    .clk          (clk),
    .reset        (reset),
    .access_valid (access_valid),
    .req          (req),
    .lru_mode     (lru_mode),
    .ready        (ready),
    .done         (done),
    .result       (result),
    .stats        (stats)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////////////////////////

  task automatic add_row(input logic rst_before, input logic lru,
                         input logic [`CACHE_ADDR_W-1:0] addr,
                         input cache_sim_pkg::access_op_e op,
                         input logic exp_l1, input logic exp_l2, input logic [1:0] hold);
    row_t r;
    r.rst_before = rst_before;
    r.lru        = lru;
    r.addr       = addr;
    r.op         = op;
    r.exp_l1     = exp_l1;
    r.exp_l2     = exp_l2;
    r.hold       = hold;
    rows.push_back(r);
  endtask

  task automatic load_table();
    // Cold miss in both levels, then a repeat that stays in L1
    add_row(0, 0, 32'h0000_0100, cache_sim_pkg::op_read,  0, 0, 0);
    add_row(0, 0, 32'h0000_0100, cache_sim_pkg::op_write, 1, 0, 2);
    // Three blocks in L1 set 0 push the first out, L2 set 0 still holds it
    add_row(1, 0, 32'h0000_0000, cache_sim_pkg::op_read,  0, 0, 0);
    add_row(0, 0, 32'h0000_0040, cache_sim_pkg::op_write, 0, 0, 0);
    add_row(0, 0, 32'h0000_0080, cache_sim_pkg::op_read,  0, 0, 0);
    add_row(0, 0, 32'h0000_0000, cache_sim_pkg::op_read,  0, 1, 1);
    add_row(0, 0, 32'h0000_0000, cache_sim_pkg::op_read,  1, 0, 0);
    // A B A C A under FIFO, so the oldest entry A is dropped by C
    add_row(1, 0, 32'h0000_0000, cache_sim_pkg::op_read,  0, 0, 0);
    add_row(0, 0, 32'h0000_0040, cache_sim_pkg::op_read,  0, 0, 0);
    add_row(0, 0, 32'h0000_0000, cache_sim_pkg::op_read,  1, 0, 2);
    add_row(0, 0, 32'h0000_0080, cache_sim_pkg::op_read,  0, 0, 0);
    add_row(0, 0, 32'h0000_0000, cache_sim_pkg::op_read,  0, 1, 0);
    // Same sequence under LRU, where the hit on A makes B the victim
    add_row(1, 1, 32'h0000_0000, cache_sim_pkg::op_read,  0, 0, 0);
    add_row(0, 1, 32'h0000_0040, cache_sim_pkg::op_read,  0, 0, 0);
    add_row(0, 1, 32'h0000_0000, cache_sim_pkg::op_write, 1, 0, 1);
    add_row(0, 1, 32'h0000_0080, cache_sim_pkg::op_read,  0, 0, 0);
    add_row(0, 1, 32'h0000_0000, cache_sim_pkg::op_read,  1, 0, 0);
    // A hit just before the reset is a cold miss again after it
    add_row(1, 1, 32'h0000_0000, cache_sim_pkg::op_read,  0, 0, 0);
    add_row(0, 1, 32'h0000_0000, cache_sim_pkg::op_write, 1, 0, 2);
    // Two byte addresses inside one block share the entry
    add_row(0, 1, 32'h0000_1230, cache_sim_pkg::op_write, 0, 0, 1);
    add_row(0, 1, 32'h0000_1234, cache_sim_pkg::op_read,  1, 0, 0);
  endtask

  ////////////////////////////////////////////////////////////
  // Checking helpers
  ////////////////////////////////////////////////////////////

  task automatic compare_value(input string ctx, input string name,
                               input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("error: %s %s got %h expected %h", ctx, name, got, exp);
    end
  endtask

  // Counters are read one edge after the last done so they have settled
  task automatic compare_stats(input string ctx);
    compare_value(ctx, "stats.accesses",  stats.accesses,  expected_stats.accesses);
    compare_value(ctx, "stats.writes",    stats.writes,    expected_stats.writes);
    compare_value(ctx, "stats.l1_hits",   stats.l1_hits,   expected_stats.l1_hits);
    compare_value(ctx, "stats.l1_misses", stats.l1_misses, expected_stats.l1_misses);
    compare_value(ctx, "stats.l2_hits",   stats.l2_hits,   expected_stats.l2_hits);
    compare_value(ctx, "stats.l2_misses", stats.l2_misses, expected_stats.l2_misses);
  endtask

  ////////////////////////////////////////////////////////////
  // One access
  ////////////////////////////////////////////////////////////

  task automatic run_row(input int n);
    row_t  r;
    string ctx;
    int    errors_before;
    int    wait_cycles;
    r             = rows[n];
    ctx           = $sformatf("row %0d", n);
    errors_before = error_count;

    if (r.rst_before) begin
      @(posedge clk);
      compare_stats({ctx, " before reset"});
      reset    <= 1'b1;
      lru_mode <= r.lru;
      repeat (2) @(posedge clk);
      reset          <= 1'b0;
      expected_stats = '0;
      @(posedge clk);
      compare_stats({ctx, " after reset"});
    end else begin
      lru_mode <= r.lru;
    end

    req.addr     <= r.addr;
    req.op       <= r.op;
    access_valid <= 1'b1;

    // The strobe is taken on the first edge where ready is also high
    wait_cycles = 0;
    do begin
      @(posedge clk);
      wait_cycles++;
    end while (!ready && wait_cycles < WAIT_LIMIT);
    if (!ready) begin
      error_count++;
      access_valid <= 1'b0;
      $display("%s: ready never went high, access not started", ctx);
      return;
    end

    // Strobe left high during the busy cycles must not start another access
    repeat (r.hold) @(posedge clk);
    access_valid <= 1'b0;

    wait_cycles = 0;
    do begin
      @(posedge clk);
      wait_cycles++;
    end while (!done && wait_cycles < WAIT_LIMIT);
    if (!done) begin
      error_count++;
      $display("%s: done never arrived for the access", ctx);
      return;
    end

    compare_value(ctx, "result.l1_hit",    result.l1_hit,    r.exp_l1);
    compare_value(ctx, "result.l2_lookup", result.l2_lookup, !r.exp_l1);
    compare_value(ctx, "result.l2_hit",    result.l2_hit,    r.exp_l2);
    compare_value(ctx, "result.op",        result.op,        r.op);
    compare_value(ctx, "ready",            ready,            1'b1);

    // L2 counters only move on an L1 miss
    expected_stats.accesses++;
    if (r.op == cache_sim_pkg::op_write) expected_stats.writes++;
    if (r.exp_l1) begin
      expected_stats.l1_hits++;
    end else begin
      expected_stats.l1_misses++;
      if (r.exp_l2) expected_stats.l2_hits++;
      else expected_stats.l2_misses++;
    end

    $display("%s addr %h op %0d lru %0d l1_hit %0d l2_hit %0d: %s", ctx, r.addr, r.op,
             r.lru, r.exp_l1, r.exp_l2, (error_count == errors_before) ? "ok" : "mismatch");
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    reset          = 1'b1;
    access_valid   = 1'b0;
    req            = '0;
    lru_mode       = 1'b0;
    expected_stats = '0;
    check_count    = 0;
    error_count    = 0;
    load_table();

    repeat (2) @(posedge clk);
    reset <= 1'b0;

    for (int i = 0; i < rows.size(); i++) begin
      run_row(i);
    end

    @(posedge clk);
    compare_stats("final");
    error_count += u_cache_sim_top.u_props.fail_count;

    $display("checks %0d errors %0d assertion failures %0d", check_count, error_count,
             u_cache_sim_top.u_props.fail_count);
    if (error_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // Each row needs well under 10 cycles, reset rows included
  initial begin : watchdog
    int limit_cycles;
    #1;
    limit_cycles = rows.size() * 10 + 20;
    repeat (limit_cycles) @(posedge clk);
    $display("watchdog: run did not finish within %0d cycles", limit_cycles);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: list.f
+incdir+.
cache_sim_pkg.sv
cache_addr_decode.sv
cache_tag_set.sv
cache_sim_control.sv
cache_stat_counters.sv
cache_sim_top.sv
cache_sim_properties.sv
cache_sim_tb.sv
